/* run.sh */
#!/bin/sh
# Build and run the multicore testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module multicore_tb -Mdir obj_dir -o multicore_sim -f sim.f
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed"
	exit $status
fi

./obj_dir/multicore_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed"
	exit $status
fi

echo "Simulation finished"
exit 0

/* sim.f */
verilog/mc_pkg.sv
verilog/sample_fetch.sv
verilog/fir_core.sv
verilog/result_collector.sv
verilog/multicore_top.sv
tb/multicore_props.sv
tb/multicore_tb.sv

/* tb/multicore_props.sv */
`timescale 1ns/1ps
`default_nettype none

module multicore_props import mc_pkg::*; (
	input logic    clk,
	input logic    rst_n,
	input logic    sample_req,
	input logic    sample_ack,
	input logic    result_req,
	input logic    result_ack,
	input result_t result_out
);

	// Requests are cleared by the synchronous reset
	assert property (@(posedge clk) !rst_n |=> !sample_req && !result_req)
		else $error("request high during reset");

	// Input handshake
	assert property (@(posedge clk) disable iff (!rst_n)
		sample_req && !sample_ack |=> sample_req)
		else $error("sample_req fell before sample_ack rose");

	assert property (@(posedge clk) disable iff (!rst_n)
		$rose(sample_req) |-> !sample_ack)
		else $error("sample_req rose while sample_ack was high");

	// Output handshake
	assert property (@(posedge clk) disable iff (!rst_n)
		result_req && !result_ack |=> result_req)
		else $error("result_req fell before result_ack rose");

	assert property (@(posedge clk) disable iff (!rst_n)
		$rose(result_req) |-> !result_ack)
		else $error("result_req rose while result_ack was high");

	// Data holds from the rise of req until ack falls
	assert property (@(posedge clk) disable iff (!rst_n)
		(result_req || result_ack) && $past(result_req || result_ack) |-> $stable(result_out))
		else $error("result_out changed during a transfer");

endmodule

`default_nettype wire

/* tb/multicore_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module multicore_tb import mc_pkg::*; ();

	localparam int NUM_CORES = 4;
	localparam int NUM_SAMPLES = 40;
	localparam int NUM_RESULTS = NUM_SAMPLES * NUM_CORES;
	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 10;
	localparam int CYCLES_PER_RESULT = 40;
	// Long enough for any core to have finished another result
	localparam int DRAIN_CYCLES = 4 * (NUM_TAPS + 2);
	localparam int TIMEOUT_NS =
		(NUM_RESULTS * CYCLES_PER_RESULT + RESET_CYCLES + DRAIN_CYCLES) * CLK_PERIOD;
	localparam int SAMPLE_MAX = 2 ** (SAMPLE_W - 1) - 1;
	localparam int SAMPLE_MIN = -(2 ** (SAMPLE_W - 1));
	localparam logic [31:0] SEED = 32'h29f8_70a5;

	logic clk;
	logic rst_n;
	sample_t sample_in;
	logic sample_req;
	logic sample_ack;
	result_t result_out;
	logic result_req;
	logic result_ack;

	sample_t samples [NUM_SAMPLES];
	longint history [NUM_TAPS];
	int exp_core [$];
	longint exp_value [$];
	int pending;

	multicore_top #(
		.NUM_CORES(NUM_CORES)
	) multicore_top_inst (
		.clk(clk),
		.rst_n(rst_n),
		.sample_in(sample_in),
		.sample_req(sample_req),
		.sample_ack(sample_ack),
		.result_out(result_out),
		.result_req(result_req),
		.result_ack(result_ack)
	);

	bind multicore_top multicore_props multicore_props_inst (
		.clk(clk),
		.rst_n(rst_n),
		.sample_req(sample_req),
		.sample_ack(sample_ack),
		.result_req(result_req),
		.result_ack(result_ack),
		.result_out(result_out)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("Checks failed");
		$fatal(1, "Simulation stopped on error");
	endtask

	task automatic report_mismatch(input string check, input longint expected,
			input longint actual);
		stop_with_failure($sformatf("[FAIL] %s expected %0d actual %0d",
			check, expected, actual));
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge clk);
	endtask

	// Random values with runs of full-scale samples to reach the extreme sums
	task automatic build_samples();
		for (int i = 0; i < NUM_SAMPLES; i++) begin
			if (i >= 8 && i < 12) begin
				samples[i] = sample_t'(SAMPLE_MIN);
			end else if (i >= 16 && i < 20) begin
				samples[i] = sample_t'(SAMPLE_MAX);
			end else if (i >= 24 && i < 28) begin
				samples[i] = (i % 2 == 1) ? sample_t'(SAMPLE_MAX) : sample_t'(SAMPLE_MIN);
			end else if (i % 9 == 4) begin
				samples[i] = sample_t'(SAMPLE_MAX);
			end else begin
				samples[i] = sample_t'($urandom);
			end
		end
	endtask

	// Reference FIR, newest sample weighted by table entry 0
	task automatic model_sample(input sample_t s);
		longint acc;
		for (int k = NUM_TAPS - 1; k > 0; k--) begin
			history[k] = history[k-1];
		end
		history[0] = longint'(s);
		for (int c = 0; c < NUM_CORES; c++) begin
			acc = 0;
			for (int k = 0; k < NUM_TAPS; k++) begin
				acc += longint'(COEF_TABLE[c][k]) * history[k];
			end
			exp_core.push_back(c);
			exp_value.push_back(acc);
		end
		pending += NUM_CORES;
	endtask

	task automatic await_first_request();
		int waited;
		waited = 0;
		while (!sample_req && waited < 4) begin
			@(posedge clk);
			waited++;
		end
		assert (sample_req) else begin
			stop_with_failure("sample_req did not rise after reset");
		end
	endtask

	task automatic drive_samples();
		for (int i = 0; i < NUM_SAMPLES; i++) begin
			while (!sample_req) begin
				@(posedge clk);
			end
			idle_cycles($urandom_range(3, 0));
			sample_in <= samples[i];
			sample_ack <= 1'b1;
			model_sample(samples[i]);
			@(posedge clk);
			while (sample_req) begin
				@(posedge clk);
			end
			idle_cycles($urandom_range(3, 0));
			sample_ack <= 1'b0;
		end
	endtask

	task automatic collect_results();
		int exp_id;
		longint exp_val;
		for (int n = 0; n < NUM_RESULTS; n++) begin
			while (!result_req) begin
				@(posedge clk);
			end
			assert (exp_core.size() > 0) else begin
				stop_with_failure("A result arrived with no sample outstanding");
			end
			exp_id = exp_core.pop_front();
			exp_val = exp_value.pop_front();
			pending--;
			assert (int'(result_out.core_id) == exp_id) else begin
				report_mismatch($sformatf("result %0d core_id", n), exp_id,
					int'(result_out.core_id));
			end
			assert (longint'($signed(result_out.value)) == exp_val) else begin
				report_mismatch($sformatf("result %0d value", n), exp_val,
					longint'($signed(result_out.value)));
			end
			idle_cycles($urandom_range(6, 0));
			result_ack <= 1'b1;
			@(posedge clk);
			while (result_req) begin
				@(posedge clk);
			end
			idle_cycles($urandom_range(6, 0));
			result_ack <= 1'b0;
		end
	endtask

	// A new sample is fetched only after every result of the last one has left
	assert property (@(posedge clk) disable iff (!rst_n) $rose(sample_req) |-> pending == 0)
		else stop_with_failure("sample_req rose while results were still pending");

	initial begin
		clk = 1'b0;
		rst_n <= 1'b0;
		sample_in <= '0;
		sample_ack <= 1'b0;
		result_ack <= 1'b0;
		pending = 0;
		for (int k = 0; k < NUM_TAPS; k++) begin
			history[k] = 0;
		end
		void'($urandom(SEED));
		build_samples();
		repeat (RESET_CYCLES) @(posedge clk);
		assert (!sample_req && !result_req) else begin
			stop_with_failure("A request was high during reset");
		end
		rst_n <= 1'b1;
		await_first_request();
		fork
			drive_samples();
			collect_results();
		join
		// No further sample was sent, so the output stream must stay idle
		idle_cycles(DRAIN_CYCLES);
		if (result_req) begin
			stop_with_failure("An extra result appeared after the last expected one");
		end else begin
			$display("All checks passed");
			$finish;
		end
	end

	// Watchdog
	initial begin
		#(TIMEOUT_NS);
		stop_with_failure("Timeout before all results arrived");
	end

endmodule

`default_nettype wire

/* verilog/fir_core.sv */
`timescale 1ns/1ps
`default_nettype none

module fir_core import mc_pkg::*; #(
	parameter int CORE_ID = 0
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       sample_valid,
	input  sample_t                    sample_bcast,
	output logic                       ready,
	output logic                       done,
	output logic signed [RESULT_W-1:0] value,
	input  logic                       take
);

	localparam int PROD_W = SAMPLE_W + COEF_W;

	typedef enum logic [1:0] {
		CORE_EMPTY,
		CORE_MAC,
		CORE_FULL
	} core_state_t;

	core_state_t state;
	logic [TAP_IDX_W-1:0] tap_idx;
	logic last_tap;
	logic load;
	sample_t taps [NUM_TAPS];
	coef_t coef;
	logic signed [PROD_W-1:0] product;
	logic signed [RESULT_W-1:0] acc;

	assign load = (state == CORE_EMPTY) && sample_valid;
	assign last_tap = (tap_idx == TAP_IDX_W'(NUM_TAPS - 1));

	// One tap per cycle through a single multiplier
	assign coef = coef_t'(COEF_TABLE[CORE_ID][tap_idx]);
	assign product = PROD_W'(taps[tap_idx]) * PROD_W'(coef);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= CORE_EMPTY;
			tap_idx <= '0;
		end else begin
			case (state)
				CORE_EMPTY: begin
					if (sample_valid) begin
						tap_idx <= '0;
						state <= CORE_MAC;
					end
				end
				CORE_MAC: begin
					tap_idx <= tap_idx + 1'b1;
					if (last_tap) begin
						state <= CORE_FULL;
					end
				end
				CORE_FULL: begin
					// Result stays put until the collector takes it
					if (take) begin
						state <= CORE_EMPTY;
					end
				end
				default: begin
					state <= CORE_EMPTY;
				end
			endcase
		end
	end

	// Delay line starts from silence
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_TAPS; i++) begin
				taps[i] <= '0;
			end
		end else if (load) begin
			taps[0] <= sample_bcast;
			for (int i = 1; i < NUM_TAPS; i++) begin
				taps[i] <= taps[i-1];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			acc <= '0;
		end else if (state == CORE_MAC) begin
			acc <= acc + RESULT_W'(product);
		end
	end

	assign ready = (state == CORE_EMPTY);
	assign done = (state == CORE_FULL);
	assign value = acc;

endmodule

`default_nettype wire

/* verilog/mc_pkg.sv */
`default_nettype none

package mc_pkg;

	// Datapath widths
	localparam int SAMPLE_W = 19;
	localparam int COEF_W = 7;
	localparam int NUM_TAPS = 4;

	// Four 26-bit products fit exactly in 28 bits
	localparam int RESULT_W = 28;

	localparam int TAP_IDX_W = $clog2(NUM_TAPS);

	// Coefficient table depth and core number width
	localparam int MAX_CORES = 8;
	localparam int CORE_ID_W = 3;

	typedef logic signed [SAMPLE_W-1:0] sample_t;
	typedef logic signed [COEF_W-1:0] coef_t;

	// One row per core, every entry within the signed 7-bit range.
	// Entry k weights the sample k steps back, entry 0 is the newest sample
	localparam int COEF_TABLE [MAX_CORES][NUM_TAPS] = '{
		'{ 63, -64,  63, -64},
		'{  1,   2,   3,   4},
		'{-64, -64, -64, -64},
		'{ 63,  63,  63,  63},
		'{  5, -17,  29,  -3},
		'{ -1,   0,  40, -12},
		'{ 12,  25, -33,   7},
		'{  0, -50,  50,   1}
	};

	// Tagged result on the output stream
	typedef struct packed {
		logic [CORE_ID_W-1:0]       core_id;
		logic signed [RESULT_W-1:0] value;
	} result_t;

endpackage

`default_nettype wire

/* verilog/multicore_top.sv */
`timescale 1ns/1ps
`default_nettype none

module multicore_top import mc_pkg::*; #(
	parameter int NUM_CORES = 4
) (
	input  logic    clk,
	input  logic    rst_n,
	input  sample_t sample_in,
	output logic    sample_req,
	input  logic    sample_ack,
	output result_t result_out,
	output logic    result_req,
	input  logic    result_ack
);

	logic sample_valid;
	sample_t sample_bcast;

	// Per-core status, gathered by core number
	logic [NUM_CORES-1:0] core_ready;
	logic [NUM_CORES-1:0] core_done;
	logic [NUM_CORES-1:0] core_take;
	logic signed [RESULT_W-1:0] core_value [NUM_CORES];

	sample_fetch #(
		.NUM_CORES(NUM_CORES)
	) sample_fetch_inst (
		.clk(clk),
		.rst_n(rst_n),
		.sample_in(sample_in),
		.sample_ack(sample_ack),
		.sample_req(sample_req),
		.core_ready(core_ready),
		.sample_valid(sample_valid),
		.sample_bcast(sample_bcast)
	);

	generate
		for (genvar i = 0; i < NUM_CORES; i++) begin : gen_core
			fir_core #(
				.CORE_ID(i)
			) fir_core_inst (
				.clk(clk),
				.rst_n(rst_n),
				.sample_valid(sample_valid),
				.sample_bcast(sample_bcast),
				.ready(core_ready[i]),
				.done(core_done[i]),
				.value(core_value[i]),
				.take(core_take[i])
			);
		end
	endgenerate

	result_collector #(
		.NUM_CORES(NUM_CORES)
	) result_collector_inst (
		.clk(clk),
		.rst_n(rst_n),
		.core_done(core_done),
		.core_value(core_value),
		.core_take(core_take),
		.result_req(result_req),
		.result_ack(result_ack),
		.result_out(result_out)
	);

endmodule

`default_nettype wire

/* verilog/result_collector.sv */
`timescale 1ns/1ps
`default_nettype none

module result_collector import mc_pkg::*; #(
	parameter int NUM_CORES = 4
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic [NUM_CORES-1:0]       core_done,
	input  logic signed [RESULT_W-1:0] core_value [NUM_CORES],
	output logic [NUM_CORES-1:0]       core_take,
	output logic                       result_req,
	input  logic                       result_ack,
	output result_t                    result_out
);

	localparam int PTR_W = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1;

	typedef enum logic [1:0] {
		COLL_WAIT_DONE,
		COLL_ACK_RISE,
		COLL_ACK_FALL
	} coll_state_t;

	coll_state_t state;
	logic [PTR_W-1:0] ptr;
	logic [PTR_W-1:0] ptr_next;
	logic at_last;
	logic launch;

	// Round-robin over the cores in number order
	assign at_last = (ptr == PTR_W'(NUM_CORES - 1));
	assign ptr_next = at_last ? '0 : ptr + 1'b1;

	// Current core has a result and the sink is idle
	assign launch = (state == COLL_WAIT_DONE) && core_done[ptr] && !result_ack;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= COLL_WAIT_DONE;
			ptr <= '0;
			result_req <= 1'b0;
			core_take <= '0;
		end else begin
			core_take <= '0;
			case (state)
				COLL_WAIT_DONE: begin
					if (launch) begin
						result_req <= 1'b1;
						state <= COLL_ACK_RISE;
					end
				end
				COLL_ACK_RISE: begin
					if (result_ack) begin
						result_req <= 1'b0;
						core_take[ptr] <= 1'b1;
						state <= COLL_ACK_FALL;
					end
				end
				COLL_ACK_FALL: begin
					if (!result_ack) begin
						ptr <= ptr_next;
						state <= COLL_WAIT_DONE;
					end
				end
				default: begin
					state <= COLL_WAIT_DONE;
					result_req <= 1'b0;
				end
			endcase
		end
	end

	// Loaded once per transfer, so it holds through the whole handshake
	always_ff @(posedge clk) begin
		if (launch) begin
			result_out.core_id <= CORE_ID_W'(ptr);
			result_out.value <= core_value[ptr];
		end
	end

endmodule

`default_nettype wire

/* verilog/sample_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module sample_fetch import mc_pkg::*; #(
	parameter int NUM_CORES = 4
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  sample_t              sample_in,
	input  logic                 sample_ack,
	output logic                 sample_req,
	input  logic [NUM_CORES-1:0] core_ready,
	output logic                 sample_valid,
	output sample_t              sample_bcast
);

	typedef enum logic [1:0] {
		FETCH_IDLE,
		FETCH_ACK_RISE,
		FETCH_ACK_FALL
	} fetch_state_t;

	fetch_state_t state;
	logic all_ready;
	logic capture;

	// Only fetch once every core has been drained
	assign all_ready = &core_ready;

	// First cycle with ack seen high
	assign capture = (state == FETCH_ACK_RISE) && sample_ack;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= FETCH_IDLE;
			sample_req <= 1'b0;
			sample_valid <= 1'b0;
		end else begin
			sample_valid <= 1'b0;
			case (state)
				FETCH_IDLE: begin
					if (all_ready && !sample_ack) begin
						sample_req <= 1'b1;
						state <= FETCH_ACK_RISE;
					end
				end
				FETCH_ACK_RISE: begin
					if (sample_ack) begin
						sample_req <= 1'b0;
						sample_valid <= 1'b1;
						state <= FETCH_ACK_FALL;
					end
				end
				FETCH_ACK_FALL: begin
					// Handshake closes once the source lets go of ack
					if (!sample_ack) begin
						state <= FETCH_IDLE;
					end
				end
				default: begin
					state <= FETCH_IDLE;
					sample_req <= 1'b0;
				end
			endcase
		end
	end

	// Broadcast register, held until the next fetch
	always_ff @(posedge clk) begin
		if (capture) begin
			sample_bcast <= sample_in;
		end
	end

endmodule

`default_nettype wire
